// File: mm_ram_defs.svh
// ---------------------------------------------------------
// widths, peripheral addresses and test-status codes
// for the memory-mapped RAM model
// ---------------------------------------------------------
`ifndef MM_RAM_DEFS_SVH
`define MM_RAM_DEFS_SVH

// byte-address width of the RAM, 4 KiB
`define MM_RAM_ADDR_WIDTH 12

// data bus and interrupt vector widths
`define MM_DATA_WIDTH 32
`define MM_IRQ_WIDTH  32

// test status and exit
`define MM_ADDR_TESTSTATUS 32'h2000_0000
`define MM_ADDR_EXIT       32'h2000_0004

// timer, debug request and cycle counter
`define MM_ADDR_TIMERREG 32'h1500_0000
`define MM_ADDR_TIMERVAL 32'h1500_0004
`define MM_ADDR_DBG      32'h1500_0008
`define MM_ADDR_TICKS    32'h1500_1004

// values written to the test-status register
`define MM_PASS_CODE 32'd123456789
`define MM_FAIL_CODE 32'd1

`endif

// File: mm_bus_pkg.sv
// ---------------------------------------------------------
// data bus types and read-source selection
// ---------------------------------------------------------
`include "mm_ram_defs.svh"

package mm_bus_pkg;

    // one data word on the bus
    typedef logic [`MM_DATA_WIDTH-1:0] word_t;

    // one enable per byte lane
    typedef logic [`MM_DATA_WIDTH/8-1:0] be_t;

    // where the read data of an accepted request comes from
    typedef enum logic [1:0] {
        RSEL_RAM   = 2'd0,
        RSEL_TICKS = 2'd1,
        RSEL_NONE  = 2'd2
    } rsel_e;

endpackage

// File: mm_periph_pkg.sv
// ---------------------------------------------------------
// command types for the interrupt timer and the
// debug-request controller
// ---------------------------------------------------------
package mm_periph_pkg;

    // timer register write, one load strobe per register
    typedef struct packed {
        logic        load_mask;
        logic        load_count;
        logic [31:0] value;
    } timer_wr_t;

    // debug command word as written to the DBG address
    typedef struct packed {
        // level driven onto debug_req after the delay
        logic        value;
        // 1 selects pulse mode, 0 level mode
        logic        pulse;
        logic        rsvd_29;
        // pulse length in cycles, 0 counts as 1
        logic [12:0] duration;
        logic        rsvd_15;
        // start delay in cycles, 0 counts as 1
        logic [14:0] delay;
    } dbg_cmd_t;

endpackage

// File: mm_mem_if.sv
// ---------------------------------------------------------
// decoded RAM access, decoder to RAM
// ---------------------------------------------------------
`timescale 1ns/100ps
`include "mm_ram_defs.svh"

interface mm_mem_if;
    import mm_bus_pkg::*;

    logic                          req;
    // word index, byte offset already dropped
    logic [`MM_RAM_ADDR_WIDTH-3:0] word_addr;
    logic                          we;
    be_t                           be;
    word_t                         wdata;

    modport dec (output req, word_addr, we, be, wdata);
    modport mem (input req, word_addr, we, be, wdata);

endinterface

// File: mm_addr_decoder.sv
// ---------------------------------------------------------
// address decoder for the data port, steers each access
// to the RAM or a peripheral and registers the status
// and exit pulses
// ---------------------------------------------------------
`timescale 1ns/100ps
`include "mm_ram_defs.svh"

module mm_addr_decoder (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    data_req_i,
    input  logic [31:0]             data_addr_i,
    input  logic                    data_we_i,
    input  mm_bus_pkg::be_t         data_be_i,
    input  mm_bus_pkg::word_t       data_wdata_i,
    mm_mem_if.dec                   mem,
    output mm_periph_pkg::timer_wr_t timer_wr_o,
    output logic                    dbg_wr_o,
    output mm_periph_pkg::dbg_cmd_t dbg_cmd_o,
    output logic                    ticks_clr_o,
    output logic                    rd_o,
    output mm_bus_pkg::rsel_e       rsel_o,
    output logic                    tests_passed_o,
    output logic                    tests_failed_o,
    output logic                    exit_valid_o,
    output mm_bus_pkg::word_t       exit_value_o
);
    import mm_bus_pkg::*;
    import mm_periph_pkg::*;

    logic in_ram;
    logic wr;

    // RAM sits below 2^MM_RAM_ADDR_WIDTH
    assign in_ram = (data_addr_i[31:`MM_RAM_ADDR_WIDTH] == '0);
    assign wr     = data_req_i & data_we_i;
    assign rd_o   = data_req_i & ~data_we_i;

    // ---------------------------------------------------------
    // RAM side
    // ---------------------------------------------------------
    assign mem.req       = data_req_i & in_ram;
    assign mem.word_addr = data_addr_i[`MM_RAM_ADDR_WIDTH-1:2];
    assign mem.we        = data_we_i;
    assign mem.be        = data_be_i;
    assign mem.wdata     = data_wdata_i;

    // ---------------------------------------------------------
    // peripheral strobes
    // ---------------------------------------------------------
    always_comb begin
        timer_wr_o.load_mask  = wr && (data_addr_i == `MM_ADDR_TIMERREG);
        timer_wr_o.load_count = wr && (data_addr_i == `MM_ADDR_TIMERVAL);
        timer_wr_o.value      = data_wdata_i;
    end

    assign dbg_wr_o    = wr && (data_addr_i == `MM_ADDR_DBG);
    assign dbg_cmd_o   = dbg_cmd_t'(data_wdata_i);
    assign ticks_clr_o = wr && (data_addr_i == `MM_ADDR_TICKS);

    // read source, writes and unmapped reads return zero
    always_comb begin
        rsel_o = RSEL_NONE;
        if (rd_o) begin
            if (in_ram) begin
                rsel_o = RSEL_RAM;
            end else if (data_addr_i == `MM_ADDR_TICKS) begin
                rsel_o = RSEL_TICKS;
            end
        end
    end

    // ---------------------------------------------------------
    // test status and exit, one cycle after the accept
    // ---------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
        end else begin
            tests_passed_o <= wr && (data_addr_i == `MM_ADDR_TESTSTATUS)
                              && (data_wdata_i == `MM_PASS_CODE);
            tests_failed_o <= wr && (data_addr_i == `MM_ADDR_TESTSTATUS)
                              && (data_wdata_i == `MM_FAIL_CODE);
            exit_valid_o   <= wr && (data_addr_i == `MM_ADDR_EXIT);
        end
    end

    // exit value stays until the next exit write
    always_ff @(posedge clk_i) begin
        if (wr && (data_addr_i == `MM_ADDR_EXIT)) begin
            exit_value_o <= data_wdata_i;
        end
    end

endmodule

// File: mm_sram.sv
// ---------------------------------------------------------
// single-port word RAM with byte enables and
// registered read data
// ---------------------------------------------------------
`timescale 1ns/100ps
`include "mm_ram_defs.svh"

module mm_sram (
    input  logic              clk_i,
    mm_mem_if.mem             mem,
    output mm_bus_pkg::word_t rdata_o
);
    import mm_bus_pkg::*;

    localparam int num_words = 2 ** (`MM_RAM_ADDR_WIDTH - 2);
    localparam int num_bytes = $bits(be_t);

    word_t mem_q [num_words];

    // write the enabled lanes, or fetch the word for the next cycle
    always_ff @(posedge clk_i) begin
        if (mem.req) begin
            if (mem.we) begin
                for (int b = 0; b < num_bytes; b++) begin
                    if (mem.be[b]) begin
                        mem_q[mem.word_addr][8*b +: 8] <= mem.wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata_o <= mem_q[mem.word_addr];
            end
        end
    end

endmodule

// File: mm_irq_timer.sv
// ---------------------------------------------------------
// countdown timer driving the masked interrupt vector,
// bits cleared one at a time by acknowledge
// ---------------------------------------------------------
`timescale 1ns/100ps
`include "mm_ram_defs.svh"

module mm_irq_timer (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  mm_periph_pkg::timer_wr_t timer_wr_i,
    input  logic                     irq_ack_i,
    input  logic [4:0]               irq_id_i,
    output logic [`MM_IRQ_WIDTH-1:0] irq_o
);

    logic [`MM_IRQ_WIDTH-1:0] mask_q;
    logic [31:0]              cnt_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_o  <= '0;
        end else begin
            if (timer_wr_i.load_mask) begin
                mask_q <= timer_wr_i.value[`MM_IRQ_WIDTH-1:0];
            end

            // a new count overrides the running one
            if (timer_wr_i.load_count) begin
                cnt_q <= timer_wr_i.value;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 32'd1;
            end

            // expiry wins over an acknowledge in the same cycle
            if (cnt_q == 32'd1) begin
                irq_o <= mask_q;
            end else if (irq_ack_i) begin
                irq_o[irq_id_i] <= 1'b0;
            end
        end
    end

endmodule

// File: mm_debug_req_ctrl.sv
// ---------------------------------------------------------
// debug request generator, level or pulse after a
// programmable start delay
// ---------------------------------------------------------
`timescale 1ns/100ps

module mm_debug_req_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    dbg_wr_i,
    input  mm_periph_pkg::dbg_cmd_t dbg_cmd_i,
    output logic                    debug_req_o
);

    logic [14:0] start_cnt_q;
    logic [12:0] dur_cnt_q;
    logic        value_q;
    logic        idle;

    // commands are dropped while a previous one is still running
    assign idle = (start_cnt_q == '0) && (dur_cnt_q == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            start_cnt_q <= '0;
            dur_cnt_q   <= '0;
            value_q     <= 1'b0;
            debug_req_o <= 1'b0;
        end else if (dbg_wr_i && idle) begin
            value_q <= dbg_cmd_i.value;

            // zero delay still waits one cycle
            if (dbg_cmd_i.delay == '0) begin
                start_cnt_q <= 15'd1;
            end else begin
                start_cnt_q <= dbg_cmd_i.delay;
            end

            // level mode has no duration
            if (!dbg_cmd_i.pulse) begin
                dur_cnt_q <= '0;
            end else if (dbg_cmd_i.duration == '0) begin
                dur_cnt_q <= 13'd1;
            end else begin
                dur_cnt_q <= dbg_cmd_i.duration;
            end
        end else if (start_cnt_q != '0) begin
            start_cnt_q <= start_cnt_q - 15'd1;
            if (start_cnt_q == 15'd1) begin
                debug_req_o <= value_q;
            end
        end else if (dur_cnt_q != '0) begin
            // pulse phase starts once the delay has run out
            dur_cnt_q <= dur_cnt_q - 13'd1;
            if (dur_cnt_q == 13'd1) begin
                debug_req_o <= ~value_q;
            end
        end
    end

endmodule

// File: mm_read_rsp.sv
// ---------------------------------------------------------
// read response stage: rvalid, read-source register,
// cycle counter with snapshot and the read-data mux
// ---------------------------------------------------------
`timescale 1ns/100ps

module mm_read_rsp (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              rd_i,
    input  logic              req_i,
    input  mm_bus_pkg::rsel_e rsel_i,
    input  logic              ticks_clr_i,
    input  mm_bus_pkg::word_t ram_rdata_i,
    output logic              data_rvalid_o,
    output mm_bus_pkg::word_t data_rdata_o
);
    import mm_bus_pkg::*;

    rsel_e rsel_q;
    word_t cycle_cnt_q;
    word_t ticks_q;

    // ---------------------------------------------------------
    // handshake and source tracking
    // ---------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_rvalid_o <= 1'b0;
            rsel_q        <= RSEL_NONE;
            cycle_cnt_q   <= '0;
        end else begin
            // every accepted request, read or write, gets rvalid next cycle
            data_rvalid_o <= req_i;
            if (req_i) begin
                rsel_q <= rsel_i;
            end

            if (ticks_clr_i) begin
                cycle_cnt_q <= '0;
            end else begin
                cycle_cnt_q <= cycle_cnt_q + 1'b1;
            end
        end
    end

    // counter value as seen at the accept edge
    always_ff @(posedge clk_i) begin
        if (rd_i && (rsel_i == RSEL_TICKS)) begin
            ticks_q <= cycle_cnt_q;
        end
    end

    // ---------------------------------------------------------
    // read data mux
    // ---------------------------------------------------------
    always_comb begin
        case (rsel_q)
            RSEL_RAM:   data_rdata_o = ram_rdata_i;
            RSEL_TICKS: data_rdata_o = ticks_q;
            default:    data_rdata_o = '0;
        endcase
    end

endmodule

// File: mm_ram.sv
// ---------------------------------------------------------
// memory-mapped RAM model top level: decoder, RAM,
// timer, debug controller and read response
// ---------------------------------------------------------
`timescale 1ns/100ps
`include "mm_ram_defs.svh"

module mm_ram (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     data_req_i,
    input  logic [31:0]              data_addr_i,
    input  logic                     data_we_i,
    input  mm_bus_pkg::be_t          data_be_i,
    input  mm_bus_pkg::word_t        data_wdata_i,
    input  logic                     irq_ack_i,
    input  logic [4:0]               irq_id_i,
    output logic                     data_gnt_o,
    output logic                     data_rvalid_o,
    output mm_bus_pkg::word_t        data_rdata_o,
    output logic [`MM_IRQ_WIDTH-1:0] irq_o,
    output logic                     debug_req_o,
    output logic                     tests_passed_o,
    output logic                     tests_failed_o,
    output logic                     exit_valid_o,
    output mm_bus_pkg::word_t        exit_value_o
);
    import mm_bus_pkg::*;
    import mm_periph_pkg::*;

    mm_mem_if  mem ();

    timer_wr_t timer_wr;
    logic      dbg_wr;
    dbg_cmd_t  dbg_cmd;
    logic      ticks_clr;
    logic      rd;
    rsel_e     rsel_d;
    word_t     ram_rdata;

    // no stalls, every request is granted at once
    assign data_gnt_o = data_req_i;

    // ---------------------------------------------------------
    // input side
    // ---------------------------------------------------------
    mm_addr_decoder u_decoder (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_wdata_i   (data_wdata_i),
        .mem            (mem.dec),
        .timer_wr_o     (timer_wr),
        .dbg_wr_o       (dbg_wr),
        .dbg_cmd_o      (dbg_cmd),
        .ticks_clr_o    (ticks_clr),
        .rd_o           (rd),
        .rsel_o         (rsel_d),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    // ---------------------------------------------------------
    // RAM and peripherals
    // ---------------------------------------------------------
    mm_sram u_sram (
        .clk_i   (clk_i),
        .mem     (mem.mem),
        .rdata_o (ram_rdata)
    );

    mm_irq_timer u_timer (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .timer_wr_i (timer_wr),
        .irq_ack_i  (irq_ack_i),
        .irq_id_i   (irq_id_i),
        .irq_o      (irq_o)
    );

    mm_debug_req_ctrl u_debug (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .dbg_wr_i    (dbg_wr),
        .dbg_cmd_i   (dbg_cmd),
        .debug_req_o (debug_req_o)
    );

    // ---------------------------------------------------------
    // output side
    // ---------------------------------------------------------
    mm_read_rsp u_read_rsp (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .rd_i          (rd),
        .req_i         (data_req_i),
        .rsel_i        (rsel_d),
        .ticks_clr_i   (ticks_clr),
        .ram_rdata_i   (ram_rdata),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o)
    );

endmodule

// File: tb_clk_gen.sv
// ------------------------------------------------------------
// testbench clock (4 ns period) and active-low reset
// ------------------------------------------------------------
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset held for two full cycles, released on a falling edge
    initial begin
        rst_no = 1'b0;
        repeat (2) @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

// File: tb_mm_ram.sv
// ------------------------------------------------------------
// directed testbench for the memory-mapped RAM model
// covering RAM, status and exit, timer, ticks and debug request
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "mm_ram_defs.svh"

module tb_mm_ram;

    localparam int timeout_cycles = 100;
    localparam int ram_words      = 2 ** (`MM_RAM_ADDR_WIDTH - 2);

    logic        clk;
    logic        rst_n;
    logic        req;
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic        irq_ack;
    logic [4:0]  irq_id;
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic [31:0] irq;
    logic        debug_req;
    logic        tests_passed;
    logic        tests_failed;
    logic        exit_valid;
    logic [31:0] exit_value;

    integer      seed;
    logic [31:0] ref_mem [ram_words];
    // status outputs seen in the rvalid cycle of the last access
    logic        rsp_passed;
    logic        rsp_failed;
    logic        rsp_exit_valid;

    tb_clk_gen u_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    mm_ram dut (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .data_req_i     (req),
        .data_addr_i    (addr),
        .data_we_i      (we),
        .data_be_i      (be),
        .data_wdata_i   (wdata),
        .irq_ack_i      (irq_ack),
        .irq_id_i       (irq_id),
        .data_gnt_o     (gnt),
        .data_rvalid_o  (rvalid),
        .data_rdata_o   (rdata),
        .irq_o          (irq),
        .debug_req_o    (debug_req),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed),
        .exit_valid_o   (exit_valid),
        .exit_value_o   (exit_value)
    );

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            stop_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // inputs change and outputs are sampled 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // one access that returns in the rvalid cycle
    task automatic bus_access(input logic wr, input logic [31:0] a, input logic [3:0] b,
                              input logic [31:0] d, output logic [31:0] rd);
        int lat;
        req   = 1'b1;
        we    = wr;
        addr  = a;
        be    = b;
        wdata = d;
        #1;
        check_val("data_gnt_o", {31'b0, gnt}, {31'b0, req});
        next_cycle();
        req = 1'b0;
        we  = 1'b0;
        lat = 1;
        while (rvalid !== 1'b1) begin
            if (lat >= timeout_cycles) begin
                stop_run("timeout while waiting for data_rvalid_o after a request");
            end
            next_cycle();
            lat++;
        end
        check_val("rvalid latency", lat, 1);
        rd             = rdata;
        rsp_passed     = tests_passed;
        rsp_failed     = tests_failed;
        rsp_exit_valid = exit_valid;
    endtask

    task automatic write_word(input logic [31:0] a, input logic [3:0] b,
                              input logic [31:0] d);
        logic [31:0] unused;
        bus_access(1'b1, a, b, d, unused);
    endtask

    task automatic read_word(input logic [31:0] a, output logic [31:0] d);
        bus_access(1'b0, a, 4'hf, 32'h0, d);
    endtask

    task automatic wait_debug(input logic level, output int cycles);
        cycles = 0;
        while (debug_req !== level) begin
            if (cycles >= timeout_cycles) begin
                stop_run("timeout while waiting for debug_req_o to change");
            end
            next_cycle();
            cycles++;
        end
    endtask

    // pulses seen with the last response must be gone one cycle later
    task automatic check_status(input logic p, input logic f, input logic e);
        check_val("tests_passed_o", {31'b0, rsp_passed}, {31'b0, p});
        check_val("tests_failed_o", {31'b0, rsp_failed}, {31'b0, f});
        check_val("exit_valid_o", {31'b0, rsp_exit_valid}, {31'b0, e});
        next_cycle();
        check_val("tests_passed_o", {31'b0, tests_passed}, 32'h0);
        check_val("tests_failed_o", {31'b0, tests_failed}, 32'h0);
        check_val("exit_valid_o", {31'b0, exit_valid}, 32'h0);
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic test_ram();
        logic [31:0] addrs [8];
        logic [31:0] d;
        logic [31:0] got;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = $random(seed) & 32'h0000_0ffc;
            d = $random(seed);
            write_word(addrs[i], 4'hf, d);
            ref_mem[addrs[i][`MM_RAM_ADDR_WIDTH-1:2]] = d;
        end
        for (int i = 0; i < 8; i++) begin
            read_word(addrs[i], got);
            check_val("data_rdata_o", got, ref_mem[addrs[i][`MM_RAM_ADDR_WIDTH-1:2]]);
        end

        // a write of the lowest byte keeps the upper three bytes
        d = $random(seed);
        write_word(addrs[0], 4'b0001, d);
        ref_mem[addrs[0][`MM_RAM_ADDR_WIDTH-1:2]][7:0] = d[7:0];
        read_word(addrs[0], got);
        check_val("data_rdata_o", got, ref_mem[addrs[0][`MM_RAM_ADDR_WIDTH-1:2]]);

        // back-to-back reads give one response per cycle
        req  = 1'b1;
        addr = addrs[1];
        #1;
        check_val("data_gnt_o", {31'b0, gnt}, 32'h1);
        next_cycle();
        check_val("data_rvalid_o", {31'b0, rvalid}, 32'h1);
        check_val("data_rdata_o", rdata, ref_mem[addrs[1][`MM_RAM_ADDR_WIDTH-1:2]]);
        addr = addrs[2];
        #1;
        check_val("data_gnt_o", {31'b0, gnt}, 32'h1);
        next_cycle();
        req = 1'b0;
        check_val("data_rvalid_o", {31'b0, rvalid}, 32'h1);
        check_val("data_rdata_o", rdata, ref_mem[addrs[2][`MM_RAM_ADDR_WIDTH-1:2]]);
        next_cycle();
        check_val("data_rvalid_o", {31'b0, rvalid}, 32'h0);
        check_val("data_gnt_o", {31'b0, gnt}, 32'h0);
    endtask

    task automatic test_status();
        logic [31:0] val;
        write_word(`MM_ADDR_TESTSTATUS, 4'hf, `MM_PASS_CODE);
        check_status(1'b1, 1'b0, 1'b0);
        write_word(`MM_ADDR_TESTSTATUS, 4'hf, `MM_FAIL_CODE);
        check_status(1'b0, 1'b1, 1'b0);
        write_word(`MM_ADDR_TESTSTATUS, 4'hf, 32'h0000_0042);
        check_status(1'b0, 1'b0, 1'b0);
        val = $random(seed);
        write_word(`MM_ADDR_EXIT, 4'hf, val);
        check_val("exit_value_o", exit_value, val);
        check_status(1'b0, 1'b0, 1'b1);
        check_val("exit_value_o", exit_value, val);
    endtask

    task automatic test_timer();
        logic [31:0] mask;
        logic [31:0] rnd;
        logic [4:0]  id;
        int          cycles;
        rnd  = $random(seed);
        id   = rnd[4:0];
        mask = $random(seed) | (32'd1 << id);
        check_val("irq_o", irq, 32'h0);
        write_word(`MM_ADDR_TIMERREG, 4'hf, mask);
        write_word(`MM_ADDR_TIMERVAL, 4'hf, 32'd5);
        cycles = 0;
        while (irq !== mask) begin
            if (cycles >= timeout_cycles) begin
                stop_run("timeout while waiting for irq_o to show the mask");
            end
            next_cycle();
            cycles++;
        end
        check_val("irq latency", cycles, 5);
        irq_ack = 1'b1;
        irq_id  = id;
        next_cycle();
        irq_ack = 1'b0;
        check_val("irq_o", irq, mask & ~(32'd1 << id));
    endtask

    task automatic test_ticks();
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] got;
        int          idle;
        idle = 6;
        write_word(`MM_ADDR_TICKS, 4'hf, 32'h0);
        read_word(`MM_ADDR_TICKS, t1);
        // counter was cleared at the accept edge just before this read
        check_val("data_rdata_o", t1, 32'h0);
        repeat (idle) next_cycle();
        read_word(`MM_ADDR_TICKS, t2);
        assert (t2 > t1) else begin
            stop_run($sformatf("[FAIL] data_rdata_o: ticks 0x%08h not above 0x%08h", t2, t1));
        end
        check_val("ticks difference", t2 - t1, idle + 1);
        // unmapped addresses read as zero
        read_word(32'h3000_0000, got);
        check_val("data_rdata_o", got, 32'h0);
        read_word(32'h1500_000c, got);
        check_val("data_rdata_o", got, 32'h0);
    endtask

    task automatic test_debug();
        int cycles;
        check_val("debug_req_o", {31'b0, debug_req}, 32'h0);
        // value, pulse, rsvd, duration, rsvd, delay
        write_word(`MM_ADDR_DBG, 4'hf, {1'b1, 1'b0, 1'b0, 13'd0, 1'b0, 15'd3});
        wait_debug(1'b1, cycles);
        check_val("debug start delay", cycles, 3);
        write_word(`MM_ADDR_DBG, 4'hf, {1'b0, 1'b1, 1'b0, 13'd4, 1'b0, 15'd0});
        wait_debug(1'b0, cycles);
        check_val("debug start delay", cycles, 1);
        wait_debug(1'b1, cycles);
        check_val("debug pulse length", cycles, 4);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        int n;
        seed    = 32'h5c32_a8f2;
        req     = 1'b0;
        addr    = 32'h0;
        we      = 1'b0;
        be      = 4'h0;
        wdata   = 32'h0;
        irq_ack = 1'b0;
        irq_id  = 5'd0;
        n = 0;
        while (rst_n !== 1'b1) begin
            if (n >= timeout_cycles) begin
                stop_run("timeout while waiting for reset release");
            end
            next_cycle();
            n++;
        end
        check_val("data_rvalid_o", {31'b0, rvalid}, 32'h0);
        check_val("tests_passed_o", {31'b0, tests_passed}, 32'h0);
        check_val("tests_failed_o", {31'b0, tests_failed}, 32'h0);
        check_val("exit_valid_o", {31'b0, exit_valid}, 32'h0);
        check_val("irq_o", irq, 32'h0);
        check_val("debug_req_o", {31'b0, debug_req}, 32'h0);

        test_ram();
        test_status();
        test_timer();
        test_ticks();
        test_debug();

        $display("Test passed");
        $finish;
    end

endmodule

// File: mm_ram.f
+incdir+.
mm_bus_pkg.sv
mm_periph_pkg.sv
mm_mem_if.sv
mm_addr_decoder.sv
mm_sram.sv
mm_irq_timer.sv
mm_debug_req_ctrl.sv
mm_read_rsp.sv
mm_ram.sv
tb_clk_gen.sv
tb_mm_ram.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f mm_ram.f \
    --top-module tb_mm_ram -o tb_mm_ram_sim \
    && ./obj_dir/tb_mm_ram_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error status" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0
